// File: Makefile
TOP = mipsControlTb

.PHONY: compile run clean

compile:
	verilator --binary --assert -f files.f --top-module $(TOP) -o simv

run: compile
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: bench/mipsControlTb.sv
`include "mipsCtrl_params.svh"

module mipsControlTb import mipsCtrlPkg::*;
();

	localparam int FIELDS = 7; // columns per test line
	localparam int MAX_TESTS = 64;

	logic Clk;
	logic rst;
	instrFieldsS instr;
	logic aluZero;
	ctrlWordS ctrl;
	ctrlStateE stateOut;

	logic [31:0] testMem [0:FIELDS*MAX_TESTS-1];
	int numTests;
	int cycleCount = 0;
	int cycleLimit = 0; // 0 until the data file is read
	int errorCount;
	int testsFailed;
	integer seed;
	ctrlWordS resetWord;

	mipsControl UUT (
		.Clk(Clk),
		.rst(rst),
		.instr(instr),
		.aluZero(aluZero),
		.ctrl(ctrl),
		.stateOut(stateOut)
	);

	initial Clk = 1'b0;
	always #2 Clk = ~Clk; // period 4

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("timeout: the run was stopped after %0d cycles", cycleCount);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic tick;
		@(posedge Clk);
		#3; // sample one unit before the next edge
	endtask

	task automatic checkState(input string name, input ctrlStateE got, input ctrlStateE exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkAluSel(input string name, input aluSelE got, input aluSelE exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkSel(input string name, input muxSelT got, input muxSelT exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkWord(input string name, input ctrlWordS got, input ctrlWordS exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	// rst high for the given number of edges, then RESET once and FETCH
	task automatic holdReset(input int cycles);
		@(posedge Clk);
		#1;
		rst = 1'b1;
		#2;
		repeat (cycles - 1)
		begin
			tick();
			checkState("stateOut", stateOut, S_RESET);
			checkWord("ctrl", ctrl, resetWord);
		end
		@(posedge Clk);
		#1;
		rst = 1'b0;
		#2;
		checkState("stateOut", stateOut, S_RESET);
		checkWord("ctrl", ctrl, resetWord);
		tick();
		checkState("stateOut", stateOut, S_FETCH);
	endtask

	// control bits that each state after decode must carry
	task automatic checkStateBits;
		case (stateOut)
			S_ALU_EXEC: checkFlag("aluOutLoad", ctrl.alu.aluOutLoad, 1'b1);
			S_R_WRITE:
			begin
				checkFlag("regWrite", ctrl.regs.regWrite, 1'b1);
				checkFlag("regDst", ctrl.regs.regDst, 1'b1);
			end
			S_BRANCH: checkSel("pcSource", ctrl.pc.pcSource, 2'd1);
			S_JUMP: checkSel("pcSource", ctrl.pc.pcSource, 2'd2);
			S_LUI:
			begin
				checkFlag("regWrite", ctrl.regs.regWrite, 1'b1);
				checkSel("memToReg", ctrl.regs.memToReg, 2'd2);
			end
			S_LOAD, S_LOAD_WAIT: checkFlag("mdrLoad", ctrl.mem.mdrLoad, 1'b1);
			S_WRITE_BACK:
			begin
				checkFlag("regWrite", ctrl.regs.regWrite, 1'b1);
				checkSel("memToReg", ctrl.regs.memToReg, 2'd1);
			end
			S_STORE, S_STORE_WAIT:
			begin
				checkFlag("memWrite", ctrl.mem.memWrite, 1'b1);
				checkFlag("iOrD", ctrl.mem.iOrD, 1'b1);
			end
			S_NOP: checkWord("ctrl", ctrl, '0);
			default: ;
		endcase
	endtask

	task automatic runTest(input int t);
		int base;
		int count;
		int prevErrors;
		int randVal;
		ctrlStateE expState;
		aluSelE expAlu;
		logic expPc;
		int expCount;
		base = t * FIELDS;
		prevErrors = errorCount;
		expState = ctrlStateE'(testMem[base+3][`STATE_WIDTH-1:0]);
		expAlu = aluSelE'(testMem[base+4][`ALU_SEL_WIDTH-1:0]);
		expPc = testMem[base+5][0];
		expCount = int'(testMem[base+6]);
		while (stateOut != S_FETCH)
			tick();
		checkFlag("irWrite", ctrl.mem.irWrite, 1'b1);
		checkFlag("pcLoad", ctrl.pc.pcLoad, 1'b0);
		@(posedge Clk);
		#1;
		instr.op = testMem[base][`OP_WIDTH-1:0];
		instr.funct = testMem[base+1][`FUNCT_WIDTH-1:0];
		randVal = $random(seed); // drawn every line to keep the sequence fixed
		if (testMem[base+2] > 1)
			aluZero = randVal[0];
		else
			aluZero = testMem[base+2][0];
		#2;
		for (int i = 0; i < `FETCH_WAIT; i++)
		begin
			checkState("stateOut", stateOut, S_FETCH_WAIT);
			checkFlag("irWrite", ctrl.mem.irWrite, 1'b1);
			checkFlag("pcLoad", ctrl.pc.pcLoad, i == `FETCH_WAIT - 1); // pc + 4 at the end
			if (i == `FETCH_WAIT - 1)
				checkAluSel("aluSel", ctrl.alu.aluSel, ALU_ADD);
			tick();
		end
		checkState("stateOut", stateOut, S_DECODE);
		count = 1;
		tick();
		checkState("stateOut", stateOut, expState);
		checkAluSel("aluSel", ctrl.alu.aluSel, expAlu);
		checkFlag("pcLoad", ctrl.pc.pcLoad, expPc);
		if (expCount == 0)
		begin
			repeat (10)
			begin
				checkState("stateOut", stateOut, S_BREAK);
				checkWord("ctrl", ctrl, '0);
				tick();
			end
			holdReset(2);
			count = 0;
		end
		else
		begin
			while (stateOut != S_FETCH && count < 40)
			begin
				checkStateBits();
				count++;
				tick();
			end
			if (stateOut != S_FETCH)
			begin
				$display("the controller did not return to FETCH within 40 cycles");
				errorCount++;
			end
			checkCount("cycles", count, expCount);
		end
		if (errorCount != prevErrors)
			testsFailed++;
		$display("test %0d op %h funct %h: %s, %0d cycles", t, instr.op, instr.funct,
			(errorCount == prevErrors) ? "ok" : "FAILED", count);
	endtask

	initial
	begin
		seed = 32'h33e0dfde;
		rst = 1'b1;
		instr = '0;
		aluZero = 1'b0;
		errorCount = 0;
		testsFailed = 0;
		resetWord = '0;
		resetWord.clearRegs = 1'b1;
		for (int i = 0; i < FIELDS * MAX_TESTS; i++)
			testMem[i] = '1; // marks the end of the data
		$readmemh("bench/mipsControl_testdata.txt", testMem);
		numTests = 0;
		while (numTests < MAX_TESTS && testMem[numTests*FIELDS] != '1)
			numTests++;
		cycleLimit = 20 * numTests + 50;
		if (numTests == 0)
		begin
			$display("no test lines were read from the data file");
			errorCount++;
		end
		holdReset(7); // rst is high from time zero so 8 edges in all
		$display("test reset: %s", (errorCount == 0) ? "ok" : "FAILED");
		if (errorCount != 0)
			testsFailed++;
		for (int t = 0; t < numTests; t++)
			runTest(t);
		$display("tests %0d, failed %0d, errors %0d", numTests + 1, testsFailed, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: bench/mipsControl_testdata.txt
// columns: op funct zero state aluSel pcLoad cycles, all hex
// zero 2 = flag drawn at random, cycles 0 = halts until reset
00 20 2 04 1 0 03 // add
00 22 2 04 2 0 03 // sub
00 24 2 04 3 0 03 // and
00 26 2 04 6 0 03 // xor
04 00 0 06 2 0 02 // beq, not taken
04 00 1 06 2 1 02 // beq, taken
05 00 0 06 2 1 02 // bne, taken
05 00 1 06 2 0 02 // bne, not taken
23 00 2 09 1 0 06 // lw
2b 00 2 09 1 0 04 // sw
0f 00 2 08 0 0 02 // lui
02 00 2 07 0 1 02 // j
00 00 2 0f 0 0 02 // nop
3f 00 2 0f 0 0 02 // unknown opcode
00 3f 2 0f 0 0 02 // unknown funct
00 0d 2 10 0 0 00 // break
00 20 2 04 1 0 03 // add after the break reset
23 00 2 09 1 0 06 // lw again

// File: files.f
+incdir+hw
hw/mipsCtrlPkg.sv
hw/instrDecoder.sv
hw/ctrlSequencer.sv
hw/ctrlWordGen.sv
hw/mipsControl.sv
bench/mipsControlTb.sv

// File: hw/ctrlSequencer.sv
`include "mipsCtrl_params.svh"

module ctrlSequencer import mipsCtrlPkg::*;
(
	input logic Clk,
	input logic rst,
	input instrClassE instrClass,
	output ctrlStateE state,
	output logic waitLast,
	output instrClassE lastClass
);

	ctrlStateE nextState;
	waitCntT waitCnt;
	logic inWait;

	assign inWait = (state == S_FETCH_WAIT) || (state == S_LOAD_WAIT) || (state == S_STORE_WAIT);
	assign waitLast = inWait && (waitCnt == '0);

	always_comb
	begin
		nextState = state;
		case (state)
			S_RESET: nextState = S_FETCH;
			S_FETCH: nextState = S_FETCH_WAIT;
			S_FETCH_WAIT:
			begin
				if (waitLast)
					nextState = S_DECODE;
			end
			S_DECODE:
			begin
				case (instrClass)
					CLS_ADD, CLS_SUB, CLS_AND, CLS_XOR: nextState = S_ALU_EXEC;
					CLS_BEQ, CLS_BNE: nextState = S_BRANCH;
					CLS_LW, CLS_SW: nextState = S_MEM_ADDR;
					CLS_J: nextState = S_JUMP;
					CLS_LUI: nextState = S_LUI;
					CLS_BREAK: nextState = S_BREAK;
					// illegal words burn one idle cycle like NOP
					default: nextState = S_NOP;
				endcase
			end
			S_ALU_EXEC: nextState = S_R_WRITE;
			S_MEM_ADDR: nextState = (lastClass == CLS_SW) ? S_STORE : S_LOAD;
			S_LOAD: nextState = S_LOAD_WAIT;
			S_LOAD_WAIT:
			begin
				if (waitLast)
					nextState = S_WRITE_BACK;
			end
			S_STORE: nextState = S_STORE_WAIT;
			S_STORE_WAIT:
			begin
				if (waitLast)
					nextState = S_FETCH;
			end
			S_R_WRITE, S_BRANCH, S_JUMP, S_LUI, S_NOP, S_WRITE_BACK: nextState = S_FETCH;
			S_BREAK: nextState = S_BREAK; // halted until rst
			default: nextState = S_RESET;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
			state <= S_RESET;
		else
			state <= nextState;
	end

	// counter is loaded in the state just before each wait state
	always_ff @(posedge Clk)
	begin
		if (rst)
			waitCnt <= '0;
		else
		begin
			case (state)
				S_FETCH: waitCnt <= waitCntT'(`FETCH_WAIT - 1);
				S_LOAD: waitCnt <= waitCntT'(`LOAD_WAIT - 1);
				S_STORE: waitCnt <= waitCntT'(`STORE_WAIT - 1);
				default:
				begin
					if (waitCnt != '0)
						waitCnt <= waitCnt - 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rst)
			lastClass <= CLS_NOP;
		else if (state == S_DECODE)
			lastClass <= instrClass; // kept for exec, memory and branch states
	end

	decodeLeaves: assert property (@(posedge Clk) disable iff (rst)
		state == S_DECODE |=> state != S_DECODE);

	breakHolds: assert property (@(posedge Clk)
		(state == S_BREAK) && !rst |=> state == S_BREAK);

endmodule

// File: hw/ctrlWordGen.sv
module ctrlWordGen import mipsCtrlPkg::*;
(
	input ctrlStateE state,
	input logic waitLast,
	input instrClassE lastClass,
	input logic aluZero,
	output ctrlWordS ctrl
);

	logic branchTaken;

	assign branchTaken = (lastClass == CLS_BNE) ? ~aluZero : aluZero; // beq takes on zero

	always_comb
	begin
		ctrl = '0;
		case (state)
			S_RESET:
			begin
				ctrl.clearRegs = 1'b1;
			end
			S_FETCH:
			begin
				ctrl.mem.irWrite = 1'b1; // instruction read starts
				ctrl.mem.mdrLoad = 1'b1;
				ctrl.alu.aluSrcB = 2'd1; // pc + 4 operands
			end
			S_FETCH_WAIT:
			begin
				ctrl.mem.irWrite = 1'b1;
				ctrl.mem.mdrLoad = 1'b1;
				ctrl.alu.aluSrcB = 2'd1;
				if (waitLast)
				begin
					ctrl.pc.pcLoad = 1'b1; // pc + 4 on the last wait
					ctrl.alu.aluSel = ALU_ADD;
				end
			end
			S_DECODE:
			begin
				ctrl.regs.aLoad = 1'b1;
				ctrl.regs.bLoad = 1'b1;
				ctrl.alu.aluSel = ALU_ADD; // branch target into aluOut
				ctrl.alu.aluSrcB = 2'd3;
				ctrl.alu.aluOutLoad = 1'b1;
			end
			S_ALU_EXEC:
			begin
				case (lastClass)
					CLS_SUB: ctrl.alu.aluSel = ALU_SUB;
					CLS_AND: ctrl.alu.aluSel = ALU_AND;
					CLS_XOR: ctrl.alu.aluSel = ALU_XOR;
					default: ctrl.alu.aluSel = ALU_ADD;
				endcase
				ctrl.alu.aluSrcA = 1'b1; // A op B
				ctrl.alu.aluOutLoad = 1'b1;
			end
			S_R_WRITE:
			begin
				ctrl.regs.regWrite = 1'b1;
				ctrl.regs.regDst = 1'b1; // rd
			end
			S_BRANCH:
			begin
				ctrl.pc.pcLoad = branchTaken;
				ctrl.pc.pcSource = 2'd1; // target computed in decode
				ctrl.alu.aluSel = ALU_SUB; // compare A and B
				ctrl.alu.aluSrcA = 1'b1;
			end
			S_JUMP:
			begin
				ctrl.pc.pcLoad = 1'b1;
				ctrl.pc.pcSource = 2'd2;
			end
			S_LUI:
			begin
				ctrl.regs.regWrite = 1'b1; // into rt
				ctrl.regs.memToReg = 2'd2;
			end
			S_MEM_ADDR:
			begin
				ctrl.alu.aluSel = ALU_ADD; // A + offset
				ctrl.alu.aluSrcA = 1'b1;
				ctrl.alu.aluSrcB = 2'd2;
				ctrl.alu.aluOutLoad = 1'b1;
			end
			S_LOAD, S_LOAD_WAIT:
			begin
				ctrl.mem.iOrD = 1'b1;
				ctrl.mem.mdrLoad = 1'b1;
			end
			S_WRITE_BACK:
			begin
				ctrl.regs.regWrite = 1'b1;
				ctrl.regs.memToReg = 2'd1; // mdr
			end
			S_STORE, S_STORE_WAIT:
			begin
				ctrl.mem.memWrite = 1'b1;
				ctrl.mem.iOrD = 1'b1;
			end
			default:
			begin
				ctrl = '0; // nop, break
			end
		endcase
		// checked on the finished word
		noWriteDuringFetch: assert (!(ctrl.mem.memWrite && ctrl.mem.irWrite));
		pcLoadStates: assert (!ctrl.pc.pcLoad || (state == S_FETCH_WAIT) ||
			(state == S_BRANCH) || (state == S_JUMP));
	end

endmodule

// File: hw/instrDecoder.sv
module instrDecoder import mipsCtrlPkg::*;
(
	input instrFieldsS instr,
	output instrClassE instrClass
);

	instrClassE functClass; // class of an R-type word

	always_comb
	begin
		case (instr.funct)
			ADD_FUNCT: functClass = CLS_ADD;
			SUB_FUNCT: functClass = CLS_SUB;
			AND_FUNCT: functClass = CLS_AND;
			XOR_FUNCT: functClass = CLS_XOR;
			BREAK_FUNCT: functClass = CLS_BREAK;
			NOP_FUNCT: functClass = CLS_NOP;
			default: functClass = CLS_ILLEGAL; // unknown funct
		endcase
	end

	always_comb
	begin
		case (instr.op)
			FUNCT_OP: instrClass = functClass;
			BEQ_OP: instrClass = CLS_BEQ;
			BNE_OP: instrClass = CLS_BNE;
			LW_OP: instrClass = CLS_LW;
			SW_OP: instrClass = CLS_SW;
			LUI_OP: instrClass = CLS_LUI;
			J_OP: instrClass = CLS_J;
			default: instrClass = CLS_ILLEGAL; // unknown opcode
		endcase
	end

endmodule

// File: hw/mipsControl.sv
module mipsControl import mipsCtrlPkg::*;
(
	input logic Clk,
	input logic rst,
	input instrFieldsS instr, // held by the datapath from fetch to fetch
	input logic aluZero,
	output ctrlWordS ctrl,
	output ctrlStateE stateOut
);

	instrClassE instrClass;
	instrClassE lastClass;
	ctrlStateE state;
	logic waitLast;

	assign stateOut = state;

	instrDecoder decoder (
		.instr(instr),
		.instrClass(instrClass)
	);

	ctrlSequencer sequencer (
		.Clk(Clk),
		.rst(rst),
		.instrClass(instrClass),
		.state(state),
		.waitLast(waitLast),
		.lastClass(lastClass)
	);

	ctrlWordGen wordGen (
		.state(state),
		.waitLast(waitLast),
		.lastClass(lastClass),
		.aluZero(aluZero),
		.ctrl(ctrl)
	);

endmodule

// File: hw/mipsCtrlPkg.sv
`include "mipsCtrl_params.svh"

package mipsCtrlPkg;

	typedef logic [`OP_WIDTH-1:0] opFieldT; // raw opcode field
	typedef logic [`FUNCT_WIDTH-1:0] functFieldT; // raw funct field
	typedef logic [1:0] muxSelT; // 4-way datapath mux select
	typedef logic [3:0] waitCntT; // memory wait counter for up to 16 cycles

	typedef enum logic [`OP_WIDTH-1:0] {
		FUNCT_OP = 6'h00,
		J_OP = 6'h02,
		BEQ_OP = 6'h04,
		BNE_OP = 6'h05,
		LUI_OP = 6'h0f,
		LW_OP = 6'h23,
		SW_OP = 6'h2b
	} opCodeE;

	typedef enum logic [`FUNCT_WIDTH-1:0] {
		NOP_FUNCT = 6'h00,
		BREAK_FUNCT = 6'h0d,
		ADD_FUNCT = 6'h20,
		SUB_FUNCT = 6'h22,
		AND_FUNCT = 6'h24,
		XOR_FUNCT = 6'h26
	} functE;

	typedef enum logic [3:0] {
		CLS_ADD, CLS_SUB, CLS_AND, CLS_XOR, CLS_BEQ, CLS_BNE, CLS_LW,
		CLS_SW, CLS_LUI, CLS_J, CLS_NOP, CLS_BREAK, CLS_ILLEGAL
	} instrClassE;

	typedef enum logic [`STATE_WIDTH-1:0] {
		S_RESET, S_FETCH, S_FETCH_WAIT, S_DECODE, S_ALU_EXEC, S_R_WRITE,
		S_BRANCH, S_JUMP, S_LUI, S_MEM_ADDR, S_LOAD, S_LOAD_WAIT,
		S_WRITE_BACK, S_STORE, S_STORE_WAIT, S_NOP, S_BREAK
	} ctrlStateE;

	// codes as the ALU expects them
	typedef enum logic [`ALU_SEL_WIDTH-1:0] {
		ALU_NONE = 3'd0,
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_XOR = 3'd6
	} aluSelE;

	typedef struct packed {
		opFieldT op;
		functFieldT funct;
	} instrFieldsS;

	typedef struct packed {
		logic pcLoad;
		muxSelT pcSource; // 0 alu result, 1 aluOut, 2 jump target
	} pcCtrlS;

	typedef struct packed {
		logic memWrite;
		logic iOrD; // 0 instruction address, 1 data address
		logic mdrLoad;
		logic irWrite;
	} memCtrlS;

	typedef struct packed {
		aluSelE aluSel;
		logic aluSrcA; // 0 pc, 1 reg A
		muxSelT aluSrcB; // 0 reg B, 1 const 4, 2 imm, 3 imm << 2
		logic aluOutLoad;
	} aluCtrlS;

	typedef struct packed {
		logic regWrite;
		logic regDst; // 1 selects rd
		muxSelT memToReg; // 0 aluOut, 1 mdr, 2 upper immediate
		logic aLoad;
		logic bLoad;
	} regCtrlS;

	typedef struct packed {
		pcCtrlS pc;
		memCtrlS mem;
		aluCtrlS alu;
		regCtrlS regs;
		logic clearRegs; // clears the datapath registers
	} ctrlWordS;

endpackage

// File: hw/mipsCtrl_params.svh
`ifndef MIPSCTRL_PARAMS_SVH
`define MIPSCTRL_PARAMS_SVH

// instruction field widths
`define OP_WIDTH 6
`define FUNCT_WIDTH 6

// encoding widths
`define STATE_WIDTH 5
`define ALU_SEL_WIDTH 3

// memory wait cycles of at least 1 each
`define FETCH_WAIT 2 // extra cycles holding the instruction read
`define LOAD_WAIT 2 // extra cycles holding the data read
`define STORE_WAIT 1 // extra cycles holding the write

`endif
